// ==== design/mips_isa_pkg.sv ====
package mips_isa_pkg;

	localparam int data_w     = 32;
	localparam int reg_addr_w = 5;
	localparam int imm_w      = 16;
	localparam int jidx_w     = 26;  // J-type target index

	localparam logic [data_w-1:0] pc_step  = 32'd4;
	localparam logic [data_w-1:0] reset_pc = 32'h0000_0000;

	// Major opcode, instr[31:26]
	typedef enum logic [5:0] {
		RTYPE = 6'b000000,
		J     = 6'b000010,
		BEQ   = 6'b000100,
		BNE   = 6'b000101,
		ADDI  = 6'b001000,
		ADDIU = 6'b001001,
		LW    = 6'b100011,
		SW    = 6'b101011
	} opcode_t;

	typedef enum logic [5:0] {
		ADD  = 6'b100000,
		ADDU = 6'b100001,
		SUB  = 6'b100010,
		SUBU = 6'b100011,
		AND  = 6'b100100,
		OR   = 6'b100101,
		SLT  = 6'b101010
	} funct_t;  // R-type, instr[5:0]

endpackage

// ==== design/mips_pipe_pkg.sv ====
package mips_pipe_pkg;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT
	} alu_op_t;

	// Operand source in execute
	typedef enum logic [1:0] {
		FWD_NONE,
		FWD_WB,
		FWD_MEM
	} fwd_sel_t;

	typedef struct packed {
		logic    regwrite;
		logic    memtoreg;
		logic    memwrite;
		logic    memread;    // Load detection only
		logic    branch;
		logic    branch_ne;  // With branch, BNE
		logic    jump;
		logic    alusrc;     // Immediate as operand b
		logic    regdst;     // rd instead of rt
		alu_op_t alu_op;
	} ctrl_t;

	localparam ctrl_t ctrl_bubble = '0;

endpackage

// ==== design/bypass_if.sv ====
`timescale 1ns/10ps

interface bypass_if;

	// From EX/MEM
	logic                                mem_regwrite;
	logic [mips_isa_pkg::reg_addr_w-1:0] mem_dst;
	logic [mips_isa_pkg::data_w-1:0]     mem_value;

	// Selected writeback result, also the register file write port
	logic                                wb_regwrite;
	logic [mips_isa_pkg::reg_addr_w-1:0] wb_dst;
	logic [mips_isa_pkg::data_w-1:0]     wb_value;

	modport producer (
		output mem_regwrite, mem_dst, mem_value,
		output wb_regwrite, wb_dst, wb_value
	);

	modport consumer (
		input mem_regwrite, mem_dst, mem_value,
		input wb_regwrite, wb_dst, wb_value
	);

endinterface

// ==== design/register_file.sv ====
`timescale 1ns/10ps

module register_file (
	input  logic                                clk,
	input  logic [mips_isa_pkg::reg_addr_w-1:0] rd_addr_a,
	input  logic [mips_isa_pkg::reg_addr_w-1:0] rd_addr_b,
	output logic [mips_isa_pkg::data_w-1:0]     rd_data_a,
	output logic [mips_isa_pkg::data_w-1:0]     rd_data_b,
	bypass_if.consumer                          wb
);

	logic [mips_isa_pkg::data_w-1:0] regs [32];

	function automatic logic [mips_isa_pkg::data_w-1:0] read_port(
		input logic [mips_isa_pkg::reg_addr_w-1:0] addr
	);
		if (addr == '0)
			return '0;
		else if (wb.wb_regwrite && wb.wb_dst == addr)
			return wb.wb_value;  // Write-through
		else
			return regs[addr];
	endfunction

	always_ff @(posedge clk) begin
		if (wb.wb_regwrite && wb.wb_dst != '0)
			regs[wb.wb_dst] <= wb.wb_value;
	end

	always_comb begin
		rd_data_a = read_port(rd_addr_a);
		rd_data_b = read_port(rd_addr_b);
	end

endmodule

// ==== design/decode_stage.sv ====
`timescale 1ns/10ps

module decode_stage (
	input  logic                                clk,
	input  logic                                rst,
	input  logic [mips_isa_pkg::data_w-1:0]     instr,
	input  logic [mips_isa_pkg::data_w-1:0]     pc_plus4,
	output logic                                stall,
	input  logic                                flush,
	bypass_if.consumer                          wb,
	output mips_pipe_pkg::ctrl_t                ex_ctrl,
	output logic [mips_isa_pkg::data_w-1:0]     ex_rd1,
	output logic [mips_isa_pkg::data_w-1:0]     ex_rd2,
	output logic [mips_isa_pkg::data_w-1:0]     ex_imm,
	output logic [mips_isa_pkg::data_w-1:0]     ex_pc_plus4,
	output logic [mips_isa_pkg::reg_addr_w-1:0] ex_rs,
	output logic [mips_isa_pkg::reg_addr_w-1:0] ex_rt,
	output logic [mips_isa_pkg::reg_addr_w-1:0] ex_rd,
	output logic [mips_isa_pkg::jidx_w-1:0]     ex_jump_index
);

	logic [mips_isa_pkg::data_w-1:0]     id_instr;
	logic [mips_isa_pkg::data_w-1:0]     id_pc_plus4;
	logic [mips_isa_pkg::data_w-1:0]     rd1;
	logic [mips_isa_pkg::data_w-1:0]     rd2;
	logic [mips_isa_pkg::reg_addr_w-1:0] id_rs;
	logic [mips_isa_pkg::reg_addr_w-1:0] id_rt;
	mips_isa_pkg::opcode_t               op;
	mips_isa_pkg::funct_t                funct;
	mips_pipe_pkg::ctrl_t                ctrl;

	assign id_rs = id_instr[25:21];
	assign id_rt = id_instr[20:16];
	assign op    = mips_isa_pkg::opcode_t'(id_instr[31:26]);
	assign funct = mips_isa_pkg::funct_t'(id_instr[5:0]);

	// --------------------
	// IF/ID
	always_ff @(posedge clk) begin
		if (rst || flush)
			id_instr <= '0;  // All-zero word decodes as a no-op
		else if (!stall)
			id_instr <= instr;
	end

	always_ff @(posedge clk) begin
		if (!stall)
			id_pc_plus4 <= pc_plus4;
	end

	register_file rf0 (
		.clk       (clk),
		.rd_addr_a (id_rs),
		.rd_addr_b (id_rt),
		.rd_data_a (rd1),
		.rd_data_b (rd2),
		.wb        (wb)
	);

	// --------------------
	// Main and ALU decode
	always_comb begin
		ctrl = mips_pipe_pkg::ctrl_bubble;
		case (op)
			mips_isa_pkg::RTYPE: begin
				ctrl.regwrite = 1'b1;
				ctrl.regdst   = 1'b1;
				case (funct)
					mips_isa_pkg::ADD,
					mips_isa_pkg::ADDU: ctrl.alu_op = mips_pipe_pkg::ALU_ADD;  // No overflow trap
					mips_isa_pkg::SUB,
					mips_isa_pkg::SUBU: ctrl.alu_op = mips_pipe_pkg::ALU_SUB;
					mips_isa_pkg::AND:  ctrl.alu_op = mips_pipe_pkg::ALU_AND;
					mips_isa_pkg::OR:   ctrl.alu_op = mips_pipe_pkg::ALU_OR;
					mips_isa_pkg::SLT:  ctrl.alu_op = mips_pipe_pkg::ALU_SLT;
					default:            ctrl = mips_pipe_pkg::ctrl_bubble;
				endcase
			end
			mips_isa_pkg::LW: begin
				ctrl.regwrite = 1'b1;
				ctrl.memtoreg = 1'b1;
				ctrl.memread  = 1'b1;
				ctrl.alusrc   = 1'b1;
			end
			mips_isa_pkg::SW: begin
				ctrl.memwrite = 1'b1;
				ctrl.alusrc   = 1'b1;
			end
			mips_isa_pkg::BEQ,
			mips_isa_pkg::BNE: begin
				ctrl.branch    = 1'b1;
				ctrl.branch_ne = (op == mips_isa_pkg::BNE);
				ctrl.alu_op    = mips_pipe_pkg::ALU_SUB;  // Compare through zero flag
			end
			mips_isa_pkg::ADDI,
			mips_isa_pkg::ADDIU: begin
				ctrl.regwrite = 1'b1;
				ctrl.alusrc   = 1'b1;
			end
			mips_isa_pkg::J: ctrl.jump = 1'b1;
			default: ;  // Undefined opcode stays a bubble
		endcase
	end

	// Load in execute feeding this instruction
	assign stall = ex_ctrl.memread && ex_rt != '0 && (ex_rt == id_rs || ex_rt == id_rt);

	// --------------------
	// ID/EX
	always_ff @(posedge clk) begin
		if (rst || stall || flush)
			ex_ctrl <= mips_pipe_pkg::ctrl_bubble;
		else
			ex_ctrl <= ctrl;
	end

	always_ff @(posedge clk) begin
		ex_rd1        <= rd1;
		ex_rd2        <= rd2;
		ex_imm        <= {{(mips_isa_pkg::data_w - mips_isa_pkg::imm_w){id_instr[15]}},
		                  id_instr[mips_isa_pkg::imm_w-1:0]};
		ex_pc_plus4   <= id_pc_plus4;
		ex_rs         <= id_rs;
		ex_rt         <= id_rt;
		ex_rd         <= id_instr[15:11];
		ex_jump_index <= id_instr[mips_isa_pkg::jidx_w-1:0];
	end

endmodule

// ==== design/execute_stage.sv ====
`timescale 1ns/10ps

module execute_stage (
	input  logic                                clk,
	input  logic                                rst,
	input  mips_pipe_pkg::ctrl_t                ex_ctrl,
	input  logic [mips_isa_pkg::data_w-1:0]     ex_rd1,
	input  logic [mips_isa_pkg::data_w-1:0]     ex_rd2,
	input  logic [mips_isa_pkg::data_w-1:0]     ex_imm,
	input  logic [mips_isa_pkg::data_w-1:0]     ex_pc_plus4,
	input  logic [mips_isa_pkg::reg_addr_w-1:0] ex_rs,
	input  logic [mips_isa_pkg::reg_addr_w-1:0] ex_rt,
	input  logic [mips_isa_pkg::reg_addr_w-1:0] ex_rd,
	input  logic [mips_isa_pkg::jidx_w-1:0]     ex_jump_index,
	bypass_if.consumer                          byp,
	bypass_if.producer                          byp_out,
	output logic                                redirect,
	output logic [mips_isa_pkg::data_w-1:0]     target,
	output mips_pipe_pkg::ctrl_t                mem_ctrl,
	output logic                                mem_write,
	output logic [mips_isa_pkg::data_w-1:0]     mem_addr,
	output logic [mips_isa_pkg::data_w-1:0]     mem_wdata
);

	mips_pipe_pkg::fwd_sel_t             fwd_a;
	mips_pipe_pkg::fwd_sel_t             fwd_b;
	logic [mips_isa_pkg::data_w-1:0]     src_a;
	logic [mips_isa_pkg::data_w-1:0]     store_val;
	logic [mips_isa_pkg::data_w-1:0]     src_b;
	logic [mips_isa_pkg::data_w-1:0]     alu_y;
	logic                                zero;
	logic [mips_isa_pkg::reg_addr_w-1:0] dst;
	logic [mips_isa_pkg::reg_addr_w-1:0] mem_dst_q;

	// --------------------
	// Forwarding, memory stage first
	function automatic mips_pipe_pkg::fwd_sel_t pick_fwd(
		input logic [mips_isa_pkg::reg_addr_w-1:0] src
	);
		if (src == '0)
			return mips_pipe_pkg::FWD_NONE;
		else if (byp.mem_regwrite && byp.mem_dst == src)
			return mips_pipe_pkg::FWD_MEM;
		else if (byp.wb_regwrite && byp.wb_dst == src)
			return mips_pipe_pkg::FWD_WB;
		else
			return mips_pipe_pkg::FWD_NONE;
	endfunction

	function automatic logic [mips_isa_pkg::data_w-1:0] fwd_mux(
		input mips_pipe_pkg::fwd_sel_t        sel,
		input logic [mips_isa_pkg::data_w-1:0] reg_val
	);
		case (sel)
			mips_pipe_pkg::FWD_MEM: return byp.mem_value;
			mips_pipe_pkg::FWD_WB:  return byp.wb_value;
			default:                return reg_val;
		endcase
	endfunction

	always_comb begin
		fwd_a     = pick_fwd(ex_rs);
		fwd_b     = pick_fwd(ex_rt);
		src_a     = fwd_mux(fwd_a, ex_rd1);
		store_val = fwd_mux(fwd_b, ex_rd2);
	end

	assign src_b = ex_ctrl.alusrc ? ex_imm : store_val;
	assign dst   = ex_ctrl.regdst ? ex_rd : ex_rt;

	// --------------------
	// ALU
	always_comb begin
		case (ex_ctrl.alu_op)
			mips_pipe_pkg::ALU_SUB: alu_y = src_a - src_b;
			mips_pipe_pkg::ALU_AND: alu_y = src_a & src_b;
			mips_pipe_pkg::ALU_OR:  alu_y = src_a | src_b;
			mips_pipe_pkg::ALU_SLT:
				alu_y = {{(mips_isa_pkg::data_w-1){1'b0}}, $signed(src_a) < $signed(src_b)};
			default:                alu_y = src_a + src_b;
		endcase
	end

	assign zero = (alu_y == '0);

	// Resolved here, so two younger instructions get flushed
	assign redirect = ex_ctrl.jump || (ex_ctrl.branch && (zero ^ ex_ctrl.branch_ne));
	assign target   = ex_ctrl.jump ?
		{ex_pc_plus4[mips_isa_pkg::data_w-1:mips_isa_pkg::data_w-4], ex_jump_index, 2'b00} :
		ex_pc_plus4 + {ex_imm[mips_isa_pkg::data_w-3:0], 2'b00};

	// EX/MEM
	always_ff @(posedge clk) begin
		if (rst)
			mem_ctrl <= mips_pipe_pkg::ctrl_bubble;
		else
			mem_ctrl <= ex_ctrl;
	end

	always_ff @(posedge clk) begin
		mem_addr  <= alu_y;
		mem_wdata <= store_val;
		mem_dst_q <= dst;
	end

	assign mem_write            = mem_ctrl.memwrite;
	assign byp_out.mem_regwrite = mem_ctrl.regwrite;
	assign byp_out.mem_dst      = mem_dst_q;
	assign byp_out.mem_value    = mem_addr;  // ALU result

endmodule

// ==== design/writeback_stage.sv ====
`timescale 1ns/10ps

module writeback_stage (
	input  logic                                clk,
	input  logic                                rst,
	input  mips_pipe_pkg::ctrl_t                mem_ctrl,
	input  logic [mips_isa_pkg::data_w-1:0]     mem_result,
	input  logic [mips_isa_pkg::data_w-1:0]     mem_rdata,
	input  logic [mips_isa_pkg::reg_addr_w-1:0] mem_dst,
	bypass_if.producer                          byp_out
);

	logic                                regwrite_q;
	logic                                memtoreg_q;
	logic [mips_isa_pkg::data_w-1:0]     result_q;
	logic [mips_isa_pkg::data_w-1:0]     rdata_q;
	logic [mips_isa_pkg::reg_addr_w-1:0] dst_q;

	// MEM/WB
	always_ff @(posedge clk) begin
		if (rst) begin
			regwrite_q <= 1'b0;
			memtoreg_q <= 1'b0;
		end else begin
			regwrite_q <= mem_ctrl.regwrite;
			memtoreg_q <= mem_ctrl.memtoreg;
		end
	end

	always_ff @(posedge clk) begin
		result_q <= mem_result;
		rdata_q  <= mem_rdata;
		dst_q    <= mem_dst;
	end

	assign byp_out.wb_regwrite = regwrite_q;
	assign byp_out.wb_dst      = dst_q;
	assign byp_out.wb_value    = memtoreg_q ? rdata_q : result_q;  // Load data or ALU

endmodule

// ==== design/mips_core.sv ====
`timescale 1ns/10ps

module mips_core (
	input  logic                            clk,
	input  logic                            rst,
	output logic [mips_isa_pkg::data_w-1:0] pc,
	input  logic [mips_isa_pkg::data_w-1:0] instr,
	output logic                            memwrite,
	output logic [mips_isa_pkg::data_w-1:0] memaddr,
	output logic [mips_isa_pkg::data_w-1:0] memwritedata,
	input  logic [mips_isa_pkg::data_w-1:0] memreaddata
);

	logic [mips_isa_pkg::data_w-1:0]     pc_plus4;
	logic                                stall;
	logic                                redirect;
	logic [mips_isa_pkg::data_w-1:0]     target;
	mips_pipe_pkg::ctrl_t                ex_ctrl;
	mips_pipe_pkg::ctrl_t                mem_ctrl;
	logic [mips_isa_pkg::data_w-1:0]     ex_rd1;
	logic [mips_isa_pkg::data_w-1:0]     ex_rd2;
	logic [mips_isa_pkg::data_w-1:0]     ex_imm;
	logic [mips_isa_pkg::data_w-1:0]     ex_pc_plus4;
	logic [mips_isa_pkg::reg_addr_w-1:0] ex_rs;
	logic [mips_isa_pkg::reg_addr_w-1:0] ex_rt;
	logic [mips_isa_pkg::reg_addr_w-1:0] ex_rd;
	logic [mips_isa_pkg::jidx_w-1:0]     ex_jump_index;

	bypass_if byp ();  // Memory and writeback results

	// --------------------
	// Fetch
	assign pc_plus4 = pc + mips_isa_pkg::pc_step;

	always_ff @(posedge clk) begin
		if (rst)
			pc <= mips_isa_pkg::reset_pc;
		else if (redirect)
			pc <= target;
		else if (!stall)
			pc <= pc_plus4;
	end

	decode_stage decode0 (
		.clk           (clk),
		.rst           (rst),
		.instr         (instr),
		.pc_plus4      (pc_plus4),
		.stall         (stall),
		.flush         (redirect),
		.wb            (byp),
		.ex_ctrl       (ex_ctrl),
		.ex_rd1        (ex_rd1),
		.ex_rd2        (ex_rd2),
		.ex_imm        (ex_imm),
		.ex_pc_plus4   (ex_pc_plus4),
		.ex_rs         (ex_rs),
		.ex_rt         (ex_rt),
		.ex_rd         (ex_rd),
		.ex_jump_index (ex_jump_index)
	);

	execute_stage execute0 (
		.clk           (clk),
		.rst           (rst),
		.ex_ctrl       (ex_ctrl),
		.ex_rd1        (ex_rd1),
		.ex_rd2        (ex_rd2),
		.ex_imm        (ex_imm),
		.ex_pc_plus4   (ex_pc_plus4),
		.ex_rs         (ex_rs),
		.ex_rt         (ex_rt),
		.ex_rd         (ex_rd),
		.ex_jump_index (ex_jump_index),
		.byp           (byp),
		.byp_out       (byp),
		.redirect      (redirect),
		.target        (target),
		.mem_ctrl      (mem_ctrl),
		.mem_write     (memwrite),
		.mem_addr      (memaddr),
		.mem_wdata     (memwritedata)
	);

	// Data port reads in the same cycle
	writeback_stage writeback0 (
		.clk        (clk),
		.rst        (rst),
		.mem_ctrl   (mem_ctrl),
		.mem_result (memaddr),
		.mem_rdata  (memreaddata),
		.mem_dst    (byp.mem_dst),
		.byp_out    (byp)
	);

endmodule

// ==== testbench/mips_core_sva.sv ====
`timescale 1ns/10ps

module mips_core_sva (
	input logic                            clk,
	input logic                            rst,
	input logic [mips_isa_pkg::data_w-1:0] pc,
	input logic                            memwrite,
	input logic                            stall,
	input logic                            redirect,
	input mips_pipe_pkg::ctrl_t            ex_ctrl
);

	memwrite_low_after_rst: assert property (@(posedge clk) rst |=> !memwrite)
		else $error("memwrite high in the cycle after reset");

	pc_held_on_stall: assert property (@(posedge clk) disable iff (rst) stall |=> $stable(pc))
		else $error("pc changed across a load-use stall");

	// Both younger instructions squashed
	flush_two_bubbles: assert property (@(posedge clk) disable iff (rst)
		redirect |=> (ex_ctrl == '0) ##1 (ex_ctrl == '0))
		else $error("instruction reached execute within two cycles of a redirect");

endmodule

bind mips_core mips_core_sva sva0 (
	.clk      (clk),
	.rst      (rst),
	.pc       (pc),
	.memwrite (memwrite),
	.stall    (stall),
	.redirect (redirect),
	.ex_ctrl  (ex_ctrl)
);

// ==== testbench/mips_checker.sv ====
`timescale 1ns/10ps

module mips_checker #(
	parameter int prog_len = 24
) (
	input  logic                            clk,
	input  logic                            rst,
	input  int                              test_id,
	input  logic [mips_isa_pkg::data_w-1:0] prog [prog_len],
	input  logic [mips_isa_pkg::data_w-1:0] dmem_init [16],
	input  logic [mips_isa_pkg::data_w-1:0] pc,
	input  logic                            memwrite,
	input  logic [mips_isa_pkg::data_w-1:0] memaddr,
	input  logic [mips_isa_pkg::data_w-1:0] memwritedata,
	output logic                            done,
	output int                              errors
);

	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	string       name;
	int          store_idx;
	logic        first_cycle;

	initial begin
		done        = 1'b0;
		errors      = 0;
		store_idx   = 0;
		first_cycle = 1'b0;
	end

	// --------------------
	// Instruction-set model, no delay slots
	task automatic run_model();
		logic [31:0] regs [32];
		logic [31:0] mem [16];
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] addr;
		logic [4:0]  rd;
		int          idx;
		int          next_idx;
		name = $sformatf("rand_prog_%0d", test_id);
		exp_addr.delete();
		exp_data.delete();
		foreach (regs[i])
			regs[i] = '0;
		foreach (mem[i])
			mem[i] = dmem_init[i];
		idx = 0;
		for (int steps = 0; steps < 200; steps++) begin
			ins      = prog[idx];
			a        = regs[ins[25:21]];
			b        = regs[ins[20:16]];
			addr     = a + {{16{ins[15]}}, ins[15:0]};  // Also the ADDI sum
			rd       = ins[15:11];
			next_idx = idx + 1;
			case (ins[31:26])
				mips_isa_pkg::RTYPE: begin
					case (ins[5:0])
						mips_isa_pkg::ADD, mips_isa_pkg::ADDU: regs[rd] = a + b;
						mips_isa_pkg::SUB, mips_isa_pkg::SUBU: regs[rd] = a - b;
						mips_isa_pkg::AND: regs[rd] = a & b;
						mips_isa_pkg::OR:  regs[rd] = a | b;
						mips_isa_pkg::SLT: regs[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: ;
					endcase
				end
				mips_isa_pkg::ADDI, mips_isa_pkg::ADDIU: regs[ins[20:16]] = addr;
				mips_isa_pkg::LW: regs[ins[20:16]] = mem[addr[5:2]];
				mips_isa_pkg::SW: begin
					mem[addr[5:2]] = b;
					exp_addr.push_back(addr);
					exp_data.push_back(b);
				end
				mips_isa_pkg::BEQ: if (a == b) next_idx = idx + 1 + int'($signed(ins[15:0]));
				mips_isa_pkg::BNE: if (a != b) next_idx = idx + 1 + int'($signed(ins[15:0]));
				mips_isa_pkg::J:   next_idx = int'(ins[25:0]);
				default: ;
			endcase
			regs[0] = '0;
			if (next_idx == idx)
				break;  // J to itself ends the program
			idx = next_idx;
		end
	endtask

	// --------------------
	// Store comparison
	always @(posedge clk) begin
		if (rst) begin
			run_model();
			store_idx   = 0;
			first_cycle = 1'b1;
			done <= 1'b0;
		end else begin
			if (first_cycle && pc !== mips_isa_pkg::reset_pc) begin
				$display("[FAIL] %s pc after reset: expected %h, actual %h",
					name, mips_isa_pkg::reset_pc, pc);
				errors++;
			end
			first_cycle = 1'b0;
			if (memwrite) begin
				if (store_idx >= exp_addr.size()) begin
					$display("%s: unexpected extra store of %h to address %h",
						name, memwritedata, memaddr);
					errors++;
				end else begin
					if (memaddr !== exp_addr[store_idx]) begin
						$display("[FAIL] %s store %0d address: expected %h, actual %h",
							name, store_idx, exp_addr[store_idx], memaddr);
						errors++;
					end
					if (memwritedata !== exp_data[store_idx]) begin
						$display("[FAIL] %s store %0d data: expected %h, actual %h",
							name, store_idx, exp_data[store_idx], memwritedata);
						errors++;
					end
					store_idx++;
				end
				done <= (store_idx >= exp_addr.size());
			end
		end
	end

endmodule

// ==== testbench/tb_mips_core.sv ====
`timescale 1ns/10ps

module tb_mips_core;

	localparam int num_tests   = 20;
	localparam int prog_len    = 24;
	localparam int body_start  = 7;   // r1..r7 set up first
	localparam int store_start = 16;  // Final stores of r1..r7
	localparam int cycle_limit = num_tests * (2 * prog_len + 20);

	logic                            clk;
	logic                            rst;
	logic [mips_isa_pkg::data_w-1:0] pc;
	logic [mips_isa_pkg::data_w-1:0] instr;
	logic                            memwrite;
	logic [mips_isa_pkg::data_w-1:0] memaddr;
	logic [mips_isa_pkg::data_w-1:0] memwritedata;
	logic [mips_isa_pkg::data_w-1:0] memreaddata;

	logic [mips_isa_pkg::data_w-1:0] imem [32];
	logic [mips_isa_pkg::data_w-1:0] dmem [16];
	logic [mips_isa_pkg::data_w-1:0] prog [prog_len];
	logic [mips_isa_pkg::data_w-1:0] dmem_init [16];
	logic [31:0]                     seed;
	int                              test_id;
	int                              err_before;
	int                              failed_tests;
	int                              check_errors;
	logic                            check_done;
	int                              cycles = 0;

	mips_core dut0 (
		.clk          (clk),
		.rst          (rst),
		.pc           (pc),
		.instr        (instr),
		.memwrite     (memwrite),
		.memaddr      (memaddr),
		.memwritedata (memwritedata),
		.memreaddata  (memreaddata)
	);

	mips_checker #(.prog_len(prog_len)) check0 (
		.clk          (clk),
		.rst          (rst),
		.test_id      (test_id),
		.prog         (prog),
		.dmem_init    (dmem_init),
		.pc           (pc),
		.memwrite     (memwrite),
		.memaddr      (memaddr),
		.memwritedata (memwritedata),
		.done         (check_done),
		.errors       (check_errors)
	);

	// --------------------
	// Memory models
	assign instr       = imem[pc[6:2]];
	assign memreaddata = dmem[memaddr[5:2]];  // 16-word data window

	always @(posedge clk) begin
		if (memwrite)
			dmem[memaddr[5:2]] = memwritedata;
	end

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("Timeout after %0d cycles, rand_prog_%0d never saw all its stores",
				cycles, test_id);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// --------------------
	// Program generation
	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed;
	endfunction

	function automatic logic [31:0] enc_i(
		input mips_isa_pkg::opcode_t op,
		input logic [4:0]            rs,
		input logic [4:0]            rt,
		input logic [15:0]           imm
	);
		return {op, rs, rt, imm};
	endfunction

	function automatic mips_isa_pkg::funct_t pick_funct(input logic [2:0] n);
		case (n)
			3'd1:    return mips_isa_pkg::ADDU;
			3'd2:    return mips_isa_pkg::SUB;
			3'd3:    return mips_isa_pkg::SUBU;
			3'd4:    return mips_isa_pkg::AND;
			3'd5:    return mips_isa_pkg::OR;
			3'd6:    return mips_isa_pkg::SLT;
			default: return mips_isa_pkg::ADD;
		endcase
	endfunction

	task automatic gen_program();
		logic [31:0] r;
		logic [31:0] r2;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		int          tgt;
		for (int k = 1; k <= 7; k++) begin
			r = lcg_next();
			prog[k-1] = enc_i(mips_isa_pkg::ADDI, 5'd0, 5'(k), r[15:0]);
		end
		for (int i = body_start; i < store_start; i++) begin
			r   = lcg_next();
			r2  = lcg_next();
			rs  = {2'b00, r[18:16]};
			rt  = {2'b00, r[21:19]};
			rd  = (r[24:22] == 3'd0) ? 5'd1 : {2'b00, r[24:22]};
			tgt = i + 1 + int'(r2[31:24]) % (store_start - i);  // Forward only
			case (r[27:25])
				3'd3: prog[i] = enc_i(r[0] ? mips_isa_pkg::ADDIU : mips_isa_pkg::ADDI,
					rs, rd, r2[15:0]);
				3'd4: prog[i] = enc_i(mips_isa_pkg::LW, 5'd0, rd, {10'd0, r2[5:2], 2'b00});
				3'd5: prog[i] = enc_i(mips_isa_pkg::SW, 5'd0, rt, {10'd0, r2[5:2], 2'b00});
				3'd6: prog[i] = enc_i(r[0] ? mips_isa_pkg::BNE : mips_isa_pkg::BEQ,
					rs, rt, 16'(tgt - i - 1));
				3'd7: prog[i] = {mips_isa_pkg::J, 26'(tgt)};
				default: prog[i] = {6'b0, rs, rt, rd, 5'b0, pick_funct(r2[2:0])};
			endcase
		end
		for (int k = 1; k <= 7; k++)
			prog[store_start+k-1] = enc_i(mips_isa_pkg::SW, 5'd0, 5'(k), 16'(4 * (k + 7)));
		prog[prog_len-1] = {mips_isa_pkg::J, 26'(prog_len - 1)};  // Spins here
	endtask

	task automatic load_memories();
		for (int a = 0; a < 32; a++)
			imem[a] = (a < prog_len) ? prog[a] : '0;  // No-ops past the end
		for (int w = 0; w < 16; w++) begin
			dmem_init[w] = lcg_next();
			dmem[w]      = dmem_init[w];
		end
	endtask

	// --------------------
	// Test loop
	initial begin
		rst          = 1'b1;
		seed         = 32'h6b99;
		test_id      = 0;
		failed_tests = 0;
		err_before   = 0;
		for (int t = 0; t < num_tests; t++) begin
			gen_program();
			load_memories();
			test_id = t;
			@(negedge clk);
			rst = 1'b1;
			repeat (2) @(negedge clk);
			rst        = 1'b0;
			err_before = check_errors;
			while (!check_done)
				@(negedge clk);
			repeat (6) @(negedge clk);  // Room for a stray store to show
			if (check_errors == err_before) begin
				$display("rand_prog_%0d: passed", t);
			end else begin
				$display("rand_prog_%0d: failed with %0d errors", t, check_errors - err_before);
				failed_tests++;
			end
		end
		$display("%0d tests, %0d passed, %0d failed, %0d errors",
			num_tests, num_tests - failed_tests, failed_tests, check_errors);
		if (check_errors == 0 && failed_tests == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// ==== mips_core.f ====
design/mips_isa_pkg.sv
design/mips_pipe_pkg.sv
design/bypass_if.sv
design/register_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/writeback_stage.sv
design/mips_core.sv
testbench/mips_core_sva.sv
testbench/mips_checker.sv
testbench/tb_mips_core.sv

// ==== Makefile ====
TOP = tb_mips_core

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f mips_core.f
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
